//--- design/decoder_geometry_pkg.sv
package decoder_geometry_pkg;

    // Address layout is {round, row, column}, packed from the top bits down
    parameter int ADDRESS_BITS = 8;  // Room for up to 256 PUs

    typedef logic [ADDRESS_BITS-1:0] address_t;

    // Root seen on a missing neighbor direction, never smaller than a real root
    parameter address_t NO_NEIGHBOR_ROOT = '1;

    parameter int NEIGHBOR_COUNT = 6;

    // Bit positions in the per-PU neighbor vectors
    typedef enum logic [2:0] {
        NORTH,  // Row - 1
        SOUTH,  // Row + 1
        WEST,   // Column - 1
        EAST,   // Column + 1
        DOWN,   // Round - 1, older measurement
        UP      // Round + 1, newer measurement
    } neighbor_dir_e;

endpackage

//--- design/decoder_control_pkg.sv
package decoder_control_pkg;

    // Stage is driven as a level from outside the grid
    typedef enum logic [1:0] {
        STAGE_IDLE,                 // Hold all state
        STAGE_MEASUREMENT_LOADING,  // Shift one round in, reset roots and counters
        STAGE_GROW,                 // Grow edges around odd clusters
        STAGE_MERGE                 // Propagate the smallest root
    } stage_e;

    parameter int WEIGHT_BITS = 4;

    typedef logic [WEIGHT_BITS-1:0] weight_t;  // Edge growth counter

    parameter weight_t DEFAULT_MAX_WEIGHT = 4'd2;  // Same weight on every edge

endpackage

//--- design/neighbor_link.sv
`timescale 1ns/100ps

module neighbor_link #(
    parameter decoder_control_pkg::weight_t MAX_WEIGHT = decoder_control_pkg::DEFAULT_MAX_WEIGHT
) (
    input  logic                        clk,
    input  logic                        reset_i,
    input  decoder_control_pkg::stage_e global_stage_i,
    input  logic                        a_odd_i,
    input  logic                        b_odd_i,
    output logic                        fully_grown_o
);

    decoder_control_pkg::weight_t weight_q;

    // One extra bit so the sum never wraps before saturation
    logic [decoder_control_pkg::WEIGHT_BITS:0] grown_sum;

    // Each odd endpoint pushes the edge by one unit
    assign grown_sum = weight_q + a_odd_i + b_odd_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            weight_q <= '0;
        end else begin
            case (global_stage_i)
                decoder_control_pkg::STAGE_MEASUREMENT_LOADING: begin
                    weight_q <= '0;  // New syndrome, edges start empty
                end
                decoder_control_pkg::STAGE_GROW: begin
                    if (grown_sum >= {1'b0, MAX_WEIGHT}) begin
                        weight_q <= MAX_WEIGHT;  // Saturate
                    end else begin
                        weight_q <= decoder_control_pkg::weight_t'(grown_sum);
                    end
                end
                default: begin
                    weight_q <= weight_q;  // Idle and merge leave the edge alone
                end
            endcase
        end
    end

    // A full edge joins the two clusters and is a correction candidate
    assign fully_grown_o = (weight_q == MAX_WEIGHT);

endmodule

//--- design/processing_unit.sv
`timescale 1ns/100ps

module processing_unit #(
    parameter decoder_geometry_pkg::address_t ADDRESS     = '0,
    parameter bit                             ON_BOUNDARY = 1'b0,
    parameter decoder_control_pkg::weight_t   MAX_WEIGHT  = decoder_control_pkg::DEFAULT_MAX_WEIGHT
) (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  decoder_control_pkg::stage_e             global_stage_i,
    input  logic                                    measurement_i,
    input  logic                                    odd_i,
    input  logic [decoder_geometry_pkg::NEIGHBOR_COUNT-1:0] neighbor_fully_grown_i,
    input  decoder_geometry_pkg::address_t [decoder_geometry_pkg::NEIGHBOR_COUNT-1:0]
                                                    neighbor_roots_i,
    output logic                                    measurement_o,
    output logic                                    defect_o,
    output decoder_geometry_pkg::address_t          root_o,
    output logic                                    touches_boundary_o,
    output logic                                    busy_o
);

    logic                           measurement_q;      // Shift stage, also the defect bit
    decoder_geometry_pkg::address_t root_q;
    decoder_geometry_pkg::address_t merged_root;
    decoder_control_pkg::weight_t   boundary_weight_q;  // Growth toward the code boundary
    logic                           busy_q;

    // Smallest root among self and every neighbor behind a full edge
    always_comb begin
        merged_root = root_q;
        for (int dir = 0; dir < decoder_geometry_pkg::NEIGHBOR_COUNT; dir++) begin
            if (neighbor_fully_grown_i[dir] && (neighbor_roots_i[dir] < merged_root)) begin
                merged_root = neighbor_roots_i[dir];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            measurement_q     <= 1'b0;
            root_q            <= ADDRESS;
            boundary_weight_q <= '0;
            busy_q            <= 1'b0;
        end else begin
            case (global_stage_i)
                decoder_control_pkg::STAGE_MEASUREMENT_LOADING: begin
                    measurement_q     <= measurement_i;  // Shift one round down
                    root_q            <= ADDRESS;        // Every PU starts as its own cluster
                    boundary_weight_q <= '0;
                    busy_q            <= 1'b0;
                end
                decoder_control_pkg::STAGE_GROW: begin
                    // Only first and last rows have a boundary to grow into
                    if (ON_BOUNDARY && odd_i && (boundary_weight_q < MAX_WEIGHT)) begin
                        boundary_weight_q <= boundary_weight_q + 4'd1;
                    end
                end
                decoder_control_pkg::STAGE_MERGE: begin
                    root_q <= merged_root;
                    busy_q <= (merged_root != root_q);  // Still spreading a new root
                end
                default: begin
                    root_q <= root_q;  // Idle holds everything
                end
            endcase
        end
    end

    assign measurement_o = measurement_q;  // To the same row and column one round below
    assign defect_o      = measurement_q;
    assign root_o        = root_q;
    assign busy_o        = busy_q;

    // Counter stays at zero away from the boundary rows
    assign touches_boundary_o = (boundary_weight_q == MAX_WEIGHT);

endmodule

//--- design/cluster_parity.sv
`timescale 1ns/100ps

module cluster_parity #(
    parameter int PU_COUNT = 24
) (
    input  decoder_geometry_pkg::address_t [PU_COUNT-1:0] roots_i,
    input  logic [PU_COUNT-1:0]                           defects_i,
    input  logic [PU_COUNT-1:0]                           touches_boundary_i,
    output logic [PU_COUNT-1:0]                           odd_o
);

    // Every PU evaluates its own cluster independently, so the whole
    // network is a flat compare and reduce with no state

    for (genvar p = 0; p < PU_COUNT; p++) begin : gen_pu
        logic [PU_COUNT-1:0] member;            // PUs sharing this PU's root
        logic                defect_parity;
        logic                boundary_contact;

        always_comb begin
            for (int q = 0; q < PU_COUNT; q++) begin
                member[q] = (roots_i[q] == roots_i[p]);
            end
        end

        assign defect_parity    = ^(member & defects_i);           // Odd number of defects
        assign boundary_contact = |(member & touches_boundary_i);  // Boundary absorbs parity

        // A cluster touching the boundary can always be made even
        assign odd_o[p] = defect_parity & ~boundary_contact;
    end

endmodule

//--- design/decoding_graph.sv
`timescale 1ns/100ps

module decoding_graph #(
    parameter int                           GRID_WIDTH_X = 4,
    parameter int                           GRID_WIDTH_Z = 2,
    parameter int                           GRID_WIDTH_U = 3,
    parameter decoder_control_pkg::weight_t MAX_WEIGHT   = decoder_control_pkg::DEFAULT_MAX_WEIGHT
) (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic [GRID_WIDTH_X*GRID_WIDTH_Z-1:0]        measurements_i,
    input  decoder_control_pkg::stage_e                 global_stage_i,
    output logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] odd_clusters_o,
    output decoder_geometry_pkg::address_t [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0]
                                                        roots_o,
    output logic [GRID_WIDTH_X*GRID_WIDTH_Z*GRID_WIDTH_U-1:0] busy_o,
    output logic [(GRID_WIDTH_X-1)*GRID_WIDTH_Z + GRID_WIDTH_X*(GRID_WIDTH_Z-1)
                  + GRID_WIDTH_X*GRID_WIDTH_Z-1:0]      correction_o
);

    localparam int X_BITS = $clog2(GRID_WIDTH_X);
    localparam int Z_BITS = $clog2(GRID_WIDTH_Z);
    localparam int PU_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_PER_ROUND * GRID_WIDTH_U;
    localparam int NS_PER_ROUND = (GRID_WIDTH_X - 1) * GRID_WIDTH_Z;
    localparam int EW_PER_ROUND = GRID_WIDTH_X * (GRID_WIDTH_Z - 1);

    logic [PU_COUNT-1:0] measurement_chain;  // Each PU's stage, read by the round below
    logic [PU_COUNT-1:0] defects;
    logic [PU_COUNT-1:0] touches_boundary;

    logic [NS_PER_ROUND*GRID_WIDTH_U-1:0]     ns_grown;
    logic [EW_PER_ROUND*GRID_WIDTH_U-1:0]     ew_grown;
    logic [PU_PER_ROUND*(GRID_WIDTH_U-1)-1:0] ud_grown;  // Link k joins rounds k and k+1

    function automatic int pu_index(int i, int j, int k);
        return k * PU_PER_ROUND + i * GRID_WIDTH_Z + j;
    endfunction

    function automatic int ns_index(int i, int j, int k);
        return k * NS_PER_ROUND + i * GRID_WIDTH_Z + j;  // Indexed by the upper PU
    endfunction

    function automatic int ew_index(int i, int j, int k);
        return k * EW_PER_ROUND + i * (GRID_WIDTH_Z - 1) + j;  // Indexed by the west PU
    endfunction

    function automatic decoder_geometry_pkg::address_t pu_address(int i, int j, int k);
        return decoder_geometry_pkg::address_t'((k << (X_BITS + Z_BITS)) | (i << Z_BITS) | j);
    endfunction

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : gen_round
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : gen_row
            for (genvar j = 0; j < GRID_WIDTH_Z; j++) begin : gen_col
                logic measurement_in;
                logic [decoder_geometry_pkg::NEIGHBOR_COUNT-1:0] grown;
                decoder_geometry_pkg::address_t [decoder_geometry_pkg::NEIGHBOR_COUNT-1:0] nroots;

                if (k == GRID_WIDTH_U - 1) begin : gen_top_round
                    assign measurement_in = measurements_i[i * GRID_WIDTH_Z + j];
                end else begin : gen_lower_round
                    assign measurement_in = measurement_chain[pu_index(i, j, k + 1)];
                end

                if (i > 0) begin : gen_north
                    assign grown[decoder_geometry_pkg::NORTH]  = ns_grown[ns_index(i - 1, j, k)];
                    assign nroots[decoder_geometry_pkg::NORTH] = roots_o[pu_index(i - 1, j, k)];
                end else begin : gen_no_north
                    assign grown[decoder_geometry_pkg::NORTH]  = 1'b0;
                    assign nroots[decoder_geometry_pkg::NORTH] = decoder_geometry_pkg::NO_NEIGHBOR_ROOT;
                end

                if (i < GRID_WIDTH_X - 1) begin : gen_south
                    assign grown[decoder_geometry_pkg::SOUTH]  = ns_grown[ns_index(i, j, k)];
                    assign nroots[decoder_geometry_pkg::SOUTH] = roots_o[pu_index(i + 1, j, k)];
                end else begin : gen_no_south
                    assign grown[decoder_geometry_pkg::SOUTH]  = 1'b0;
                    assign nroots[decoder_geometry_pkg::SOUTH] = decoder_geometry_pkg::NO_NEIGHBOR_ROOT;
                end

                if (j > 0) begin : gen_west
                    assign grown[decoder_geometry_pkg::WEST]  = ew_grown[ew_index(i, j - 1, k)];
                    assign nroots[decoder_geometry_pkg::WEST] = roots_o[pu_index(i, j - 1, k)];
                end else begin : gen_no_west
                    assign grown[decoder_geometry_pkg::WEST]  = 1'b0;
                    assign nroots[decoder_geometry_pkg::WEST] = decoder_geometry_pkg::NO_NEIGHBOR_ROOT;
                end

                if (j < GRID_WIDTH_Z - 1) begin : gen_east
                    assign grown[decoder_geometry_pkg::EAST]  = ew_grown[ew_index(i, j, k)];
                    assign nroots[decoder_geometry_pkg::EAST] = roots_o[pu_index(i, j + 1, k)];
                end else begin : gen_no_east
                    assign grown[decoder_geometry_pkg::EAST]  = 1'b0;
                    assign nroots[decoder_geometry_pkg::EAST] = decoder_geometry_pkg::NO_NEIGHBOR_ROOT;
                end

                if (k > 0) begin : gen_down
                    assign grown[decoder_geometry_pkg::DOWN]  = ud_grown[pu_index(i, j, k - 1)];
                    assign nroots[decoder_geometry_pkg::DOWN] = roots_o[pu_index(i, j, k - 1)];
                end else begin : gen_no_down
                    assign grown[decoder_geometry_pkg::DOWN]  = 1'b0;
                    assign nroots[decoder_geometry_pkg::DOWN] = decoder_geometry_pkg::NO_NEIGHBOR_ROOT;
                end

                if (k < GRID_WIDTH_U - 1) begin : gen_up
                    assign grown[decoder_geometry_pkg::UP]  = ud_grown[pu_index(i, j, k)];
                    assign nroots[decoder_geometry_pkg::UP] = roots_o[pu_index(i, j, k + 1)];
                end else begin : gen_no_up
                    assign grown[decoder_geometry_pkg::UP]  = 1'b0;
                    assign nroots[decoder_geometry_pkg::UP] = decoder_geometry_pkg::NO_NEIGHBOR_ROOT;
                end

                processing_unit #(
                    .ADDRESS     (pu_address(i, j, k)),
                    .ON_BOUNDARY ((i == 0) || (i == GRID_WIDTH_X - 1)),  // First and last rows
                    .MAX_WEIGHT  (MAX_WEIGHT)
                ) u_pu (
                    .clk                    (clk),
                    .reset_i                (reset_i),
                    .global_stage_i         (global_stage_i),
                    .measurement_i          (measurement_in),
                    .odd_i                  (odd_clusters_o[pu_index(i, j, k)]),
                    .neighbor_fully_grown_i (grown),
                    .neighbor_roots_i       (nroots),
                    .measurement_o          (measurement_chain[pu_index(i, j, k)]),
                    .defect_o               (defects[pu_index(i, j, k)]),
                    .root_o                 (roots_o[pu_index(i, j, k)]),
                    .touches_boundary_o     (touches_boundary[pu_index(i, j, k)]),
                    .busy_o                 (busy_o[pu_index(i, j, k)])
                );
            end
        end
    end

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : gen_ns_round
        for (genvar i = 0; i < GRID_WIDTH_X - 1; i++) begin : gen_row
            for (genvar j = 0; j < GRID_WIDTH_Z; j++) begin : gen_col
                neighbor_link #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                    .clk            (clk),
                    .reset_i        (reset_i),
                    .global_stage_i (global_stage_i),
                    .a_odd_i        (odd_clusters_o[pu_index(i, j, k)]),
                    .b_odd_i        (odd_clusters_o[pu_index(i + 1, j, k)]),
                    .fully_grown_o  (ns_grown[ns_index(i, j, k)])
                );
            end
        end
    end

    for (genvar k = 0; k < GRID_WIDTH_U; k++) begin : gen_ew_round
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : gen_row
            for (genvar j = 0; j < GRID_WIDTH_Z - 1; j++) begin : gen_col
                neighbor_link #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                    .clk            (clk),
                    .reset_i        (reset_i),
                    .global_stage_i (global_stage_i),
                    .a_odd_i        (odd_clusters_o[pu_index(i, j, k)]),
                    .b_odd_i        (odd_clusters_o[pu_index(i, j + 1, k)]),
                    .fully_grown_o  (ew_grown[ew_index(i, j, k)])
                );
            end
        end
    end

    // Same row and column, consecutive rounds
    for (genvar k = 0; k < GRID_WIDTH_U - 1; k++) begin : gen_ud_round
        for (genvar i = 0; i < GRID_WIDTH_X; i++) begin : gen_row
            for (genvar j = 0; j < GRID_WIDTH_Z; j++) begin : gen_col
                neighbor_link #(.MAX_WEIGHT(MAX_WEIGHT)) u_link (
                    .clk            (clk),
                    .reset_i        (reset_i),
                    .global_stage_i (global_stage_i),
                    .a_odd_i        (odd_clusters_o[pu_index(i, j, k)]),
                    .b_odd_i        (odd_clusters_o[pu_index(i, j, k + 1)]),
                    .fully_grown_o  (ud_grown[pu_index(i, j, k)])
                );
            end
        end
    end

    cluster_parity #(.PU_COUNT(PU_COUNT)) u_cluster_parity (
        .roots_i            (roots_o),
        .defects_i          (defects),
        .touches_boundary_i (touches_boundary),
        .odd_o              (odd_clusters_o)
    );

    // Lowest round only: north-south edges, then east-west, then rounds 0 to 1
    assign correction_o = {ud_grown[PU_PER_ROUND-1:0],
                           ew_grown[EW_PER_ROUND-1:0],
                           ns_grown[NS_PER_ROUND-1:0]};

endmodule

//--- verification/decoding_graph_tb.sv
`timescale 1ns/100ps

module decoding_graph_tb;

    localparam int GRID_WIDTH_X = 4;
    localparam int GRID_WIDTH_Z = 2;
    localparam int GRID_WIDTH_U = 3;
    localparam int PU_PER_ROUND = GRID_WIDTH_X * GRID_WIDTH_Z;
    localparam int PU_COUNT = PU_PER_ROUND * GRID_WIDTH_U;
    localparam int CORRECTION_BITS = (GRID_WIDTH_X - 1) * GRID_WIDTH_Z
                                     + GRID_WIDTH_X * (GRID_WIDTH_Z - 1) + PU_PER_ROUND;
    localparam int RESET_CYCLES = 10;

    // Address fields are as wide as the largest index they hold
    localparam int ROW_SPAN = 1 << $clog2(GRID_WIDTH_X);
    localparam int COL_SPAN = 1 << $clog2(GRID_WIDTH_Z);

    typedef logic [PU_PER_ROUND-1:0]    round_vec_t;
    typedef logic [PU_COUNT-1:0]        pu_vec_t;
    typedef logic [CORRECTION_BITS-1:0] correction_vec_t;

    logic                                          clk;
    logic                                          reset_i;
    round_vec_t                                    measurements;
    decoder_control_pkg::stage_e                   global_stage;
    pu_vec_t                                       odd_clusters;
    decoder_geometry_pkg::address_t [PU_COUNT-1:0] roots;
    pu_vec_t                                       busy;
    correction_vec_t                               correction;

    string       cmd_q[$];     // One entry per trace command
    string       name_q[$];
    logic [31:0] arg_a_q[$];
    logic [31:0] arg_b_q[$];

    logic [31:0] lfsr_state = 32'h7d7fa6d1;
    int          cycle_count = 0;
    int          cycle_limit = 0;  // Zero until the trace length is known
    int          test_checks = 0;
    int          test_failures = 0;
    int          test_count = 0;
    int          total_checks = 0;
    int          total_failures = 0;
    string       test_name = "startup";

    decoding_graph #(
        .GRID_WIDTH_X (GRID_WIDTH_X),
        .GRID_WIDTH_Z (GRID_WIDTH_Z),
        .GRID_WIDTH_U (GRID_WIDTH_U),
        .MAX_WEIGHT   (decoder_control_pkg::DEFAULT_MAX_WEIGHT)
    ) dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .measurements_i (measurements),
        .global_stage_i (global_stage),
        .odd_clusters_o (odd_clusters),
        .roots_o        (roots),
        .busy_o         (busy),
        .correction_o   (correction)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // Column in the low field, then the row, then the round
    function automatic decoder_geometry_pkg::address_t own_address(input int pu);
        int round_k;
        int row_i;
        int col_j;
        round_k = pu / PU_PER_ROUND;
        row_i   = (pu % PU_PER_ROUND) / GRID_WIDTH_Z;
        col_j   = pu % GRID_WIDTH_Z;
        return decoder_geometry_pkg::address_t'((round_k * ROW_SPAN + row_i) * COL_SPAN + col_j);
    endfunction

    task automatic note_result(input bit ok);
        test_checks++;
        total_checks++;
        if (!ok) begin
            test_failures++;
            total_failures++;
        end
    endtask

    task automatic check_odd(input pu_vec_t expected);
        if (odd_clusters !== expected) begin
            $display("error at %0t: odd_clusters_o expected %h, got %h",
                     $time, expected, odd_clusters);
        end
        note_result(odd_clusters === expected);
    endtask

    task automatic check_correction(input correction_vec_t expected);
        if (correction !== expected) begin
            $display("error at %0t: correction_o expected %h, got %h",
                     $time, expected, correction);
        end
        note_result(correction === expected);
    endtask

    task automatic check_busy(input pu_vec_t expected);
        if (busy !== expected) begin
            $display("error at %0t: busy_o expected %h, got %h", $time, expected, busy);
        end
        note_result(busy === expected);
    endtask

    task automatic check_root(input int pu, input decoder_geometry_pkg::address_t expected);
        if (roots[pu] !== expected) begin
            $display("error at %0t: roots_o[%0d] expected %h, got %h",
                     $time, pu, expected, roots[pu]);
        end
        note_result(roots[pu] === expected);
    endtask

    // Every PU idle and still its own cluster
    task automatic expect_own_roots();
        check_busy('0);
        for (int pu = 0; pu < PU_COUNT; pu++) begin
            check_root(pu, own_address(pu));
        end
    endtask

    // Drives one clock of a stage and returns at the falling edge in idle
    task automatic step_stage(input decoder_control_pkg::stage_e stage, input round_vec_t vec);
        global_stage = stage;
        measurements = vec;
        @(negedge clk);
        global_stage = decoder_control_pkg::STAGE_IDLE;
    endtask

    task automatic merge_until_quiet();
        int cycles;
        cycles = 0;
        do begin
            step_stage(decoder_control_pkg::STAGE_MERGE, '0);
            cycles++;
        end while (busy != '0 && cycles < PU_COUNT);
        if (busy != '0) begin
            $display("merge still busy after %0d cycles at %0t", cycles, $time);
        end
        note_result(busy == '0);
    endtask

    task automatic load_random();
        round_vec_t vec;
        pu_vec_t    expected;
        for (int k = 0; k < GRID_WIDTH_U; k++) begin
            for (int b = 0; b < PU_PER_ROUND; b++) begin
                vec[b]     = lfsr_state[0];  // One LFSR step per bit
                lfsr_state = lfsr_next(lfsr_state);
            end
            step_stage(decoder_control_pkg::STAGE_MEASUREMENT_LOADING, vec);
            expected[k*PU_PER_ROUND +: PU_PER_ROUND] = vec;  // Load k ends in round k
        end
        // Before any growth each defect is a cluster of its own
        check_odd(expected);
        check_correction('0);
        expect_own_roots();
    endtask

    task automatic close_test();
        if (test_checks > 0) begin
            test_count++;
            $display("test %s: %0d checks, %0d failed", test_name, test_checks, test_failures);
        end
        test_checks   = 0;
        test_failures = 0;
    endtask

    task automatic read_trace();
        int                 fd;
        int                 count;
        string              word;
        string              name;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [8*256-1:0]   rest;
        fd = $fopen("verification/decoding_graph_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/decoding_graph_trace.txt");
            $display("Checks failed");
            $finish;
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            name = "";
            a    = '0;
            b    = '0;
            if (word.substr(0, 0) == "#") begin
                count = $fgets(rest, fd);  // Skip the comment line
            end else begin
                case (word)
                    "test":   count = ($fscanf(fd, "%s", name) == 1);
                    "load":   count = ($fscanf(fd, "%h", a) == 1);
                    "grow":   count = ($fscanf(fd, "%d", a) == 1);
                    "expect": count = ($fscanf(fd, "%h %h", a, b) == 2);
                    "root":   count = ($fscanf(fd, "%d %h", a, b) == 2);
                    default:  count = 1;  // No arguments follow
                endcase
                if (count != 1) begin
                    $display("trace command %s has missing or unreadable arguments", word);
                    note_result(1'b0);
                end
                cmd_q.push_back(word);
                name_q.push_back(name);
                arg_a_q.push_back(a);
                arg_b_q.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        reset_i      = 1'b1;
        global_stage = decoder_control_pkg::STAGE_IDLE;
        measurements = '0;
        read_trace();
        cycle_limit = RESET_CYCLES + cmd_q.size() * (PU_COUNT + 2);
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        foreach (cmd_q[n]) begin
            a = arg_a_q[n];
            b = arg_b_q[n];
            case (cmd_q[n])
                "test": begin
                    close_test();
                    test_name = name_q[n];
                end
                "load": begin
                    step_stage(decoder_control_pkg::STAGE_MEASUREMENT_LOADING,
                               a[PU_PER_ROUND-1:0]);
                end
                "grow": begin
                    repeat (a) step_stage(decoder_control_pkg::STAGE_GROW, '0);
                end
                "expect": begin
                    check_odd(a[PU_COUNT-1:0]);
                    check_correction(b[CORRECTION_BITS-1:0]);
                end
                "root":  check_root(int'(a), b[decoder_geometry_pkg::ADDRESS_BITS-1:0]);
                "merge": merge_until_quiet();
                "rload": load_random();
                "own":   expect_own_roots();
                default: begin
                    $display("unknown trace command %s", cmd_q[n]);
                    note_result(1'b0);
                end
            endcase
        end
        close_test();
        $display("tests %0d, checks %0d, failures %0d", test_count, total_checks, total_failures);
        if (total_failures == 0 && total_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verification/decoding_graph_trace.txt
# Commands: test <name> | load <round vector hex> | rload | grow <n> | merge | own
# Checks: expect <odd_clusters hex> <correction hex> | root <pu> <root hex>
test reset
expect 000000 00000
own
test shift
load 01
load 02
load 84
expect 840201 00000
own
rload
rload
test ns_pair
load 14
load 00
load 00
grow 1
merge
expect 000000 00004
root 2 02
root 4 02
test boundary
load 02
load 00
load 10
grow 2
merge
expect 741000 00842
root 1 00
root 9 00
root 20 0c
root 22 0c
test up_down
load 08
load 08
load 00
grow 1
merge
expect 000000 02000
root 11 03
test saturate
grow 3
merge
expect 000000 02000
root 11 03

//--- decoding_graph.f
design/decoder_geometry_pkg.sv
design/decoder_control_pkg.sv
design/neighbor_link.sv
design/processing_unit.sv
design/cluster_parity.sv
design/decoding_graph.sv
verification/decoding_graph_tb.sv

//--- Makefile
TOP = decoding_graph_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f decoding_graph.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --top-module decoding_graph \
		design/decoder_geometry_pkg.sv \
		design/decoder_control_pkg.sv \
		design/neighbor_link.sv \
		design/processing_unit.sv \
		design/cluster_parity.sv \
		design/decoding_graph.sv

clean:
	rm -rf obj_dir sim.log
